// ==== source/amiga_timing_pkg.sv ====
// clock phase constants for the 28 MHz timing core
// phase counter, E-clock count and one-hot phase types
// timing struct passed forward from the phase generator

`default_nettype none

package amiga_timing_pkg;

  // E-clock runs at 7 MHz / 10
  localparam int E_PHASES = 10;

  // 7 MHz counter start value, puts the first c7 enable two cycles out
  localparam logic [1:0] PHASE_RESET = 2'd2;

  typedef logic [1:0] phase_cnt_t;          // 28 -> 7 MHz divider
  typedef logic [3:0] e_cnt_t;              // 0..9 E-clock sequence
  typedef logic [E_PHASES-1:0] e_phase_t;   // one-hot on e_cnt

  // everything later stages need to know about the bus clocks
  typedef struct packed {
    logic     c7_en;    // one clk_28 pulse per 7 MHz period
    e_phase_t e_phase;  // current E phase, one-hot
    logic     e_tick;   // last c7 enable of E phase 9
  } timing_t;           // 12 bits

endpackage

`default_nettype wire

// ==== source/cia_bus_pkg.sv ====
// register bus types for the CIA-style timer block
// Wishbone request and issued register access structs
// register map, control register and ICR bit positions

`default_nettype none

package cia_bus_pkg;

  typedef logic [3:0]  reg_addr_t;   // 16 register slots
  typedef logic [7:0]  reg_data_t;   // byte wide bus
  typedef logic [15:0] timer_val_t;  // counter and latch

  // Wishbone classic inputs as seen by the slave
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat;   // write data
  } wb_req_t;         // 15 bits

  // one register access, valid for a single cycle
  typedef struct packed {
    logic      valid;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat;
  } reg_op_t;         // 14 bits

  // register map
  localparam reg_addr_t ADDR_TALO = 4'd4;
  localparam reg_addr_t ADDR_TAHI = 4'd5;
  localparam reg_addr_t ADDR_TBLO = 4'd6;
  localparam reg_addr_t ADDR_TBHI = 4'd7;
  localparam reg_addr_t ADDR_ICR  = 4'd13;
  localparam reg_addr_t ADDR_CRA  = 4'd14;
  localparam reg_addr_t ADDR_CRB  = 4'd15;

  // control register bits
  localparam int CR_START   = 0;
  localparam int CR_ONESHOT = 3;
  localparam int CR_LOAD    = 4;   // strobe, reads back as 0

  localparam int ICR_SET = 7;      // 1 sets mask bits, 0 clears them

endpackage

`default_nettype wire

// ==== source/clock_phase_gen.sv ====
// phase generator for the chip bus clocks
// 7 MHz phase counter, c1/c3 quadrature and colour clock
// one-hot E-clock sequencer and end of cycle tick

`timescale 1ns/1ps
`default_nettype none

module clock_phase_gen (
  input  wire                        clk_28,
  input  wire                        locked,   // PLL lock, async active low reset
  output amiga_timing_pkg::timing_t  timing,
  output logic                       c1,
  output logic                       c3,
  output logic                       cck
);

  amiga_timing_pkg::phase_cnt_t phase_cnt;
  amiga_timing_pkg::e_cnt_t     e_cnt;
  amiga_timing_pkg::e_phase_t   e_phase;
  logic                         clk_7;
  logic                         c7_en;
  logic                         e_last;

  // 28 -> 7 MHz divider
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      phase_cnt <= amiga_timing_pkg::PHASE_RESET;
    end else begin
      phase_cnt <= phase_cnt + 2'd1;
    end
  end

  assign clk_7 = phase_cnt[1];       // 7 MHz level
  assign c7_en = (phase_cnt == '1);  // last 28 MHz cycle of each 7 MHz period

  // quadrature pair
  // c3 trails clk_7 by a quarter period, c1 is ~c3 one more cycle on
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      c3 <= 1'b0;
      c1 <= 1'b0;
    end else begin
      c3 <= clk_7;
      c1 <= ~c3;
    end
  end

  // E-clock sequencer, steps once per 7 MHz period
  assign e_last = (e_cnt == amiga_timing_pkg::e_cnt_t'(amiga_timing_pkg::E_PHASES - 1));

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      e_cnt <= '0;
    end else if (c7_en) begin
      if (e_last) begin
        e_cnt <= '0;   // wrap 9 -> 0
      end else begin
        e_cnt <= e_cnt + 4'd1;
      end
    end
  end

  // decode, one bit per phase
  assign e_phase = amiga_timing_pkg::e_phase_t'(1) << e_cnt;

  assign cck = ~e_cnt[0];   // colour clock, half the 7 MHz rate

  // handed forward to the bus sync and the timers
  assign timing = '{
    c7_en:   c7_en,
    e_phase: e_phase,
    e_tick:  c7_en & e_last   // once per 40 clk_28 cycles
  };

endmodule

`default_nettype wire

// ==== source/eclk_bus_sync.sv ====
// Wishbone classic slave synchronized to the E-clock
// holds each access until the E cycle ends, then issues one register op
// and acknowledges with the captured read data

`timescale 1ns/1ps
`default_nettype none

module eclk_bus_sync (
  input  wire                        clk_28,
  input  wire                        locked,
  input  amiga_timing_pkg::timing_t  timing,
  input  cia_bus_pkg::wb_req_t       wb_req,
  input  cia_bus_pkg::reg_data_t     rd_data,   // from timer block, same cycle
  output cia_bus_pkg::reg_op_t       reg_op,
  output cia_bus_pkg::reg_data_t     dat_r,
  output logic                       ack
);

  typedef enum logic {
    ST_IDLE,   // waiting for a request and the E cycle end
    ST_ACK     // single ack cycle
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   pending;
  logic   issue;

  // master has an access up that we have not acked yet
  assign pending = wb_req.cyc & wb_req.stb & ~ack;

  // peripheral cycle completes only on the E-clock boundary
  assign issue = pending & timing.e_tick;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (issue) begin
          state_nxt = ST_ACK;
        end
      end
      ST_ACK: begin
        state_nxt = ST_IDLE;   // ack is one cycle only
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign ack = (state == ST_ACK);

  // read data sampled in the issue cycle
  // zero outside the ack cycle
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      dat_r <= '0;
    end else if (issue) begin
      dat_r <= rd_data;
    end else begin
      dat_r <= '0;
    end
  end

  // master holds the request steady, so pass it straight through
  assign reg_op = '{
    valid: issue,
    we:    wb_req.we,
    adr:   wb_req.adr,
    dat:   wb_req.dat
  };

endmodule

`default_nettype wire

// ==== source/cia_timer.sv ====
// CIA-style interval timers A and B
// 16-bit latches and counters, control registers
// interrupt flags, mask and irq_n

`timescale 1ns/1ps
`default_nettype none

module cia_timer (
  input  wire                        clk_28,
  input  wire                        locked,
  input  amiga_timing_pkg::timing_t  timing,
  input  cia_bus_pkg::reg_op_t       reg_op,
  output cia_bus_pkg::reg_data_t     rd_data,
  output logic                       irq_n
);

  logic                    wr_en;
  logic                    icr_rd;
  logic                    icr_wr;
  logic                    irq_any;
  logic [1:0]              uflow;      // per timer underflow this cycle
  logic [1:0]              flags;      // ICR data bits
  logic [1:0]              mask;       // ICR mask bits
  cia_bus_pkg::reg_data_t  icr_val;
  cia_bus_pkg::timer_val_t cnt_q [2];
  cia_bus_pkg::reg_data_t  cr_q  [2];

  assign wr_en  = reg_op.valid & reg_op.we;
  assign icr_wr = wr_en & (reg_op.adr == cia_bus_pkg::ADDR_ICR);
  assign icr_rd = reg_op.valid & ~reg_op.we & (reg_op.adr == cia_bus_pkg::ADDR_ICR);

  // timer A is index 0, timer B index 1
  for (genvar i = 0; i < 2; i++) begin : g_timer
    localparam cia_bus_pkg::reg_addr_t LO_ADDR =
      (i == 0) ? cia_bus_pkg::ADDR_TALO : cia_bus_pkg::ADDR_TBLO;
    localparam cia_bus_pkg::reg_addr_t HI_ADDR =
      (i == 0) ? cia_bus_pkg::ADDR_TAHI : cia_bus_pkg::ADDR_TBHI;
    localparam cia_bus_pkg::reg_addr_t CR_ADDR =
      (i == 0) ? cia_bus_pkg::ADDR_CRA : cia_bus_pkg::ADDR_CRB;

    cia_bus_pkg::timer_val_t latch;
    cia_bus_pkg::timer_val_t count;
    cia_bus_pkg::reg_data_t  cr;
    logic                    wr_lo;
    logic                    wr_hi;
    logic                    wr_cr;
    logic                    running;

    assign wr_lo   = wr_en & (reg_op.adr == LO_ADDR);
    assign wr_hi   = wr_en & (reg_op.adr == HI_ADDR);
    assign wr_cr   = wr_en & (reg_op.adr == CR_ADDR);
    assign running = cr[cia_bus_pkg::CR_START];

    // reaching zero is seen on the tick after the count gets there
    assign uflow[i] = timing.e_tick & running & (count == '0);

    always_ff @(posedge clk_28 or negedge locked) begin
      if (!locked) begin
        latch <= '1;
        count <= '1;
        cr    <= '0;   // stopped, continuous
      end else begin
        if (wr_lo) begin
          latch[7:0] <= reg_op.dat;
        end
        if (wr_hi) begin
          latch[15:8] <= reg_op.dat;
        end

        // counter, bus loads win over counting
        if (wr_hi && !running) begin
          count <= {reg_op.dat, latch[7:0]};   // stopped timer loads on hi write
        end else if (wr_cr && reg_op.dat[cia_bus_pkg::CR_LOAD]) begin
          count <= latch;                      // force load
        end else if (uflow[i]) begin
          count <= latch;                      // reload on underflow
        end else if (timing.e_tick && running) begin
          count <= count - 16'd1;
        end

        // control register, load bit is not stored
        if (wr_cr) begin
          cr <= reg_op.dat;
          cr[cia_bus_pkg::CR_LOAD] <= 1'b0;
        end else if (uflow[i] && cr[cia_bus_pkg::CR_ONESHOT]) begin
          cr[cia_bus_pkg::CR_START] <= 1'b0;   // one-shot stops itself
        end
      end
    end

    assign cnt_q[i] = count;
    assign cr_q[i]  = cr;
  end

  // interrupt flags and mask
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      flags <= '0;
      mask  <= '0;
    end else begin
      // read clears, but a new underflow in the same cycle survives
      flags <= (icr_rd ? 2'b00 : flags) | uflow;
      if (icr_wr) begin
        if (reg_op.dat[cia_bus_pkg::ICR_SET]) begin
          mask <= mask | reg_op.dat[1:0];
        end else begin
          mask <= mask & ~reg_op.dat[1:0];
        end
      end
    end
  end

  assign irq_any = |(flags & mask);
  assign irq_n   = ~irq_any;

  always_comb begin
    icr_val                       = '0;
    icr_val[1:0]                  = flags;
    icr_val[cia_bus_pkg::ICR_SET] = irq_any;   // IR summary bit
  end

  // read mux, live counter bytes
  always_comb begin
    case (reg_op.adr)
      cia_bus_pkg::ADDR_TALO: rd_data = cnt_q[0][7:0];
      cia_bus_pkg::ADDR_TAHI: rd_data = cnt_q[0][15:8];
      cia_bus_pkg::ADDR_TBLO: rd_data = cnt_q[1][7:0];
      cia_bus_pkg::ADDR_TBHI: rd_data = cnt_q[1][15:8];
      cia_bus_pkg::ADDR_ICR:  rd_data = icr_val;
      cia_bus_pkg::ADDR_CRA:  rd_data = cr_q[0];
      cia_bus_pkg::ADDR_CRB:  rd_data = cr_q[1];
      default:                rd_data = '0;   // unmapped
    endcase
  end

endmodule

`default_nettype wire

// ==== source/cia_timer_top.sv ====
// top level of the chip bus timing core
// phase generator -> E-clock bus sync -> CIA timers

`timescale 1ns/1ps
`default_nettype none

module cia_timer_top (
  input  wire                         clk_28,
  input  wire                         locked,   // PLL locked, doubles as reset
  // Wishbone classic slave
  input  wire                         cyc,
  input  wire                         stb,
  input  wire                         we,
  input  cia_bus_pkg::reg_addr_t      adr,
  input  cia_bus_pkg::reg_data_t      dat_w,
  output cia_bus_pkg::reg_data_t      dat_r,
  output logic                        ack,
  // bus phases
  output logic                        c1,
  output logic                        c3,
  output logic                        cck,
  output amiga_timing_pkg::e_phase_t  eclk,
  output logic                        irq_n
);

  amiga_timing_pkg::timing_t timing;
  cia_bus_pkg::wb_req_t      wb_req;
  cia_bus_pkg::reg_op_t      reg_op;
  cia_bus_pkg::reg_data_t    rd_data;

  assign wb_req = '{cyc: cyc, stb: stb, we: we, adr: adr, dat: dat_w};

  assign eclk = timing.e_phase;

  clock_phase_gen clock_phase_gen_inst (
    .clk_28 (clk_28),
    .locked (locked),
    .timing (timing),
    .c1     (c1),
    .c3     (c3),
    .cck    (cck)
  );

  eclk_bus_sync eclk_bus_sync_inst (
    .clk_28  (clk_28),
    .locked  (locked),
    .timing  (timing),
    .wb_req  (wb_req),
    .rd_data (rd_data),
    .reg_op  (reg_op),
    .dat_r   (dat_r),
    .ack     (ack)
  );

  cia_timer cia_timer_inst (
    .clk_28  (clk_28),
    .locked  (locked),
    .timing  (timing),
    .reg_op  (reg_op),
    .rd_data (rd_data),
    .irq_n   (irq_n)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// testbench clock and PLL lock stand-in
// 100 ns clk_28 period, locked low for the first 4 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_28,
  output logic locked
);

  initial begin
    clk_28 = 1'b0;
    forever #50 clk_28 = ~clk_28;
  end

  // released on a falling edge, like the other DUT inputs
  initial begin
    locked = 1'b0;
    repeat (4) @(posedge clk_28);
    @(negedge clk_28);
    locked = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/cia_timer_tb.sv ====
// testbench for the chip bus timing core
// phase and E-clock monitor, Wishbone access tasks
// timer reference function and read data checks

`timescale 1ns/1ps
`default_nettype none

module cia_timer_tb;

  // what a read should return, resolved when its ack arrives
  typedef struct packed {
    logic        is_count;  // live counter byte, taken from the reference
    logic        hi;        // high byte of the counter
    logic [15:0] value;     // fixed value, or the latch for a counter
    logic [31:0] start;     // wrap count at the start write
  } rd_exp_t;

  logic                       clk_28;
  logic                       locked;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  cia_bus_pkg::reg_addr_t     adr;
  cia_bus_pkg::reg_data_t     dat_w;
  cia_bus_pkg::reg_data_t     dat_r;
  logic                       ack;
  logic                       c1;
  logic                       c3;
  logic                       cck;
  amiga_timing_pkg::e_phase_t eclk;
  logic                       irq_n;

  // monitor state
  logic       run_mon;
  int         cyc_no;
  int         wrap_cnt;   // eclk 9 -> 0 transitions seen
  int         wrap_cyc;   // cycle of the last one
  int         run_len;
  logic       run_ok;
  logic [3:0] idx;
  logic [3:0] idx_q;
  logic [3:0] exp_idx;
  logic       exp_bit;
  logic [1:0] c3_hist;
  logic       ack_q;
  logic [7:0] exp_rd;
  rd_exp_t    cur;
  rd_exp_t    rd_q[$];

  tb_clock tb_clock_inst (.clk_28(clk_28), .locked(locked));

  cia_timer_top cia_timer_top_inst (
    .clk_28 (clk_28),
    .locked (locked),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .c1     (c1),
    .c3     (c3),
    .cck    (cck),
    .eclk   (eclk),
    .irq_n  (irq_n)
  );

  task automatic report_mismatch(input string sig, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("Fail at time %0t: %s is %h, expected %h", $time, sig, got, exp);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Error at time %0t: %s", $time, why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // timer loaded with latch counts down to 0, reloads on the next tick
  function automatic logic [15:0] timer_ref(input logic [15:0] latch, input int ticks);
    int period;
    period = int'(latch) + 1;
    return 16'(int'(latch) - ticks % period);
  endfunction

  // the read tick itself is not counted yet
  function automatic logic [7:0] expected_read(input rd_exp_t e, input int wraps);
    logic [15:0] cnt;
    if (!e.is_count) begin
      return e.value[7:0];
    end
    cnt = timer_ref(e.value, wraps - int'(e.start) - 1);
    return e.hi ? cnt[15:8] : cnt[7:0];
  endfunction

  function automatic logic [3:0] phase_index(input amiga_timing_pkg::e_phase_t ph);
    logic [3:0] pos;
    pos = '0;
    for (int i = 0; i < amiga_timing_pkg::E_PHASES; i++) begin
      if (ph[i]) pos = 4'(i);
    end
    return pos;
  endfunction

  // one classic cycle, returns the wrap count once the access is done
  task automatic bus_access(input logic wr, input cia_bus_pkg::reg_addr_t a,
                            input cia_bus_pkg::reg_data_t d, output int wraps);
    int waited;
    @(negedge clk_28);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    waited = 0;
    do begin
      @(negedge clk_28);
      waited++;
    end while (!ack && waited < 60);
    if (!ack) abort_run("no ack from the bus within 60 cycles");
    assert (waited <= 41) else report_mismatch("ack latency", 16'(waited), 16'd41);
    @(negedge clk_28);   // drop in the cycle after ack
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    wraps = wrap_cnt;    // no wrap can land here
  endtask

  task automatic read_expect(input cia_bus_pkg::reg_addr_t a, input logic is_count,
                             input logic hi, input logic [15:0] value, input int start);
    rd_exp_t e;
    int      wraps;
    e = '{is_count: is_count, hi: hi, value: value, start: 32'(start)};
    rd_q.push_back(e);
    bus_access(1'b0, a, 8'h00, wraps);
  endtask

  // comparing process, outputs sampled mid cycle
  always @(negedge clk_28) begin
    if (run_mon) begin
      cyc_no = cyc_no + 1;
      idx = phase_index(eclk);
      assert ($onehot(eclk)) else abort_run("eclk is not one-hot");
      exp_bit = ~idx[0];
      assert (cck == exp_bit) else report_mismatch("cck", 16'(cck), 16'(exp_bit));
      if (cyc_no > 1) begin
        exp_bit = ~c3_hist[0];   // c1 trails ~c3 by one cycle
        assert (c1 == exp_bit) else report_mismatch("c1", 16'(c1), 16'(exp_bit));
      end
      if (cyc_no > 2) begin
        exp_bit = ~c3_hist[1];   // 2 high, 2 low
        assert (c3 == exp_bit) else report_mismatch("c3", 16'(c3), 16'(exp_bit));
      end
      if (cyc_no > 1 && idx != idx_q) begin
        exp_idx = (idx_q == 4'd9) ? 4'd0 : idx_q + 4'd1;
        assert (idx == exp_idx) else report_mismatch("eclk phase", 16'(idx), 16'(exp_idx));
        if (run_ok) begin
          assert (run_len == 4) else report_mismatch("eclk phase length", 16'(run_len), 16'd4);
        end
        run_ok  = 1'b1;
        run_len = 0;
        if (idx == 4'd0) begin
          if (wrap_cnt > 0) begin
            assert (cyc_no - wrap_cyc == 40)
              else report_mismatch("eclk sequence length", 16'(cyc_no - wrap_cyc), 16'd40);
          end
          wrap_cnt = wrap_cnt + 1;
          wrap_cyc = cyc_no;
        end
      end
      run_len = run_len + 1;
      if (ack) begin
        assert (wrap_cyc == cyc_no) else abort_run("ack outside the first cycle of phase 0");
        assert (!ack_q) else abort_run("ack held high for more than one cycle");
        if (!we) begin
          if (rd_q.size() == 0) begin
            abort_run("read acknowledged with nothing expected");
          end else begin
            cur    = rd_q.pop_front();
            exp_rd = expected_read(cur, wrap_cnt);
            assert (dat_r == exp_rd) else report_mismatch("dat_r", 16'(dat_r), 16'(exp_rd));
          end
        end
      end
      c3_hist = {c3_hist[0], c3};
      ack_q   = ack;
      idx_q   = idx;
    end
  end

  initial begin
    int          seed;
    int          w;
    int          w_start;
    int          waited;
    logic [31:0] rnd;
    logic [15:0] lat_a;
    logic [15:0] lat_b;
    seed = 32'ha433;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    run_mon = 1'b0;
    cyc_no = 0;
    wrap_cnt = 0;
    wrap_cyc = 0;
    run_len = 0;
    run_ok = 1'b0;
    idx_q = '0;
    c3_hist = '0;
    ack_q = 1'b0;

    waited = 0;
    while (!locked && waited < 10) begin
      @(posedge clk_28);
      waited++;
    end
    if (!locked) abort_run("locked never went high");
    run_mon = 1'b1;

    // timer A one-shot, mask A on
    bus_access(1'b1, cia_bus_pkg::ADDR_ICR, 8'h81, w);
    assert (irq_n) else abort_run("irq_n low before any timer ran");
    for (int k = 0; k < 3; k++) begin
      rnd   = $random(seed);
      lat_a = {10'd0, rnd[5:0]};
      bus_access(1'b1, cia_bus_pkg::ADDR_TALO, lat_a[7:0], w);
      bus_access(1'b1, cia_bus_pkg::ADDR_TAHI, lat_a[15:8], w);  // loads, A stopped
      bus_access(1'b1, cia_bus_pkg::ADDR_CRA, 8'h09, w_start);   // start + one-shot
      waited = 0;
      while (irq_n && waited < 2700) begin
        @(negedge clk_28);
        waited++;
      end
      if (irq_n) abort_run("timer A interrupt never arrived");
      @(negedge clk_28);
      assert (wrap_cnt == w_start + int'(lat_a) + 1)
        else report_mismatch("timer A underflow tick", 16'(wrap_cnt - w_start), lat_a + 16'd1);
      read_expect(cia_bus_pkg::ADDR_CRA, 1'b0, 1'b0, 16'h0008, 0);   // start cleared
      read_expect(cia_bus_pkg::ADDR_ICR, 1'b0, 1'b0, 16'h0081, 0);
      assert (irq_n) else abort_run("irq_n still low after the ICR read");
    end

    // timer B continuous, mask B off, no underflow within the run
    rnd   = $random(seed);
    lat_b = rnd[15:0] | 16'h0400;
    bus_access(1'b1, cia_bus_pkg::ADDR_TBLO, lat_b[7:0], w);
    bus_access(1'b1, cia_bus_pkg::ADDR_TBHI, lat_b[15:8], w);
    bus_access(1'b1, cia_bus_pkg::ADDR_CRB, 8'h01, w_start);
    for (int k = 0; k < 6; k++) begin
      rnd = $random(seed);
      repeat (rnd[5:0]) @(negedge clk_28);   // idle gap
      read_expect(cia_bus_pkg::ADDR_TBLO, 1'b1, 1'b0, lat_b, w_start);
      read_expect(cia_bus_pkg::ADDR_TBHI, 1'b1, 1'b1, lat_b, w_start);
      assert (irq_n) else abort_run("irq_n went low with no unmasked flag");
    end
    read_expect(cia_bus_pkg::ADDR_ICR, 1'b0, 1'b0, 16'h0000, 0);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/amiga_timing_pkg.sv
source/cia_bus_pkg.sv
source/clock_phase_gen.sv
source/eclk_bus_sync.sv
source/cia_timer.sv
source/cia_timer_top.sv
bench/tb_clock.sv
bench/cia_timer_tb.sv

// ==== Makefile ====
TOP = cia_timer_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
